// File: all.f
+incdir+design
design/dcache_pkg.sv
design/dcache_way_store.sv
design/dcache_store_merge.sv
design/dcache_lookup.sv
design/dcache_ctrl.sv
design/dcache_top.sv
verification/dcache_ram_model.sv
verification/dcache_tb.sv

// File: design/dcache_ctrl.sv
/*
 * Cache controller
 * Accepts one CPU request at a time and resolves hits in the same clock.
 * A miss writes back a dirty victim, refills the line from RAM and merges
 * a pending store into it. Keeps one recency bit per set.
 */
module dcache_ctrl
    import dcache_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  cpu_req_t   cpu_req_i,
    output cpu_resp_t  cpu_resp_o,
    output mem_req_t   mem_req_o,
    input  line_t      ram_data_i,
    input  logic       ram_ready_i,
    output index_t     lookup_index_o,
    output tag_t       lookup_tag_o,
    output way_t       lru_way_o,
    input  logic       hit_i,
    input  way_t       hit_way_i,
    input  way_t       victim_way_i,
    input  logic       victim_dirty_i,
    input  tag_t       victim_tag_i,
    input  tag_entry_t tags_i [WAYS],
    input  line_t      lines_i [WAYS],
    output cpu_req_t   merge_req_o,
    output line_t      merge_line_o,
    input  line_t      merge_line_i,
    input  word_t      merge_word_i,
    output logic       tag_wr_o,
    output logic       data_wr_o,
    output way_t       wr_way_o,
    output tag_entry_t tag_entry_o,
    output line_t      line_o
);

    typedef enum logic [1:0] {
        S_COMPARE,
        S_WRITE_BACK,
        S_REFILL
    } state_e;

    state_e    state_q;
    cpu_req_t  req_q;
    cpu_req_t  sel_req;
    way_t      victim_q;
    way_t      lru_q [SETS];  // least recently used way per set
    cpu_resp_t resp_q;
    mem_req_t  mem_req_q;
    index_t    sel_index;
    tag_t      sel_tag;
    woff_t     sel_woff;
    addr_t     line_addr;
    logic      accept;
    logic      refill_done;
    word_t     resp_word;

    // live request while idle, buffered one during a miss
    always_comb begin
        sel_req     = (state_q == S_COMPARE) ? cpu_req_i : req_q;
        sel_index   = sel_req.addr[INDEX_LSB +: INDEX_W];
        sel_tag     = sel_req.addr[TAG_LSB +: TAG_W];
        sel_woff    = sel_req.addr[BOFF_W +: WOFF_W];
        line_addr   = {sel_req.addr[ADDR_W-1:INDEX_LSB], {INDEX_LSB{1'b0}}};
        accept      = (state_q == S_COMPARE) && cpu_req_i.valid && !resp_q.ready;
        refill_done = (state_q == S_REFILL) && ram_ready_i;
    end

    always_comb begin
        merge_req_o = sel_req;
        if (!sel_req.write) begin
            merge_req_o.width = WR_NONE;  // loads never modify the line
        end
    end

    assign merge_line_o = (state_q == S_REFILL) ? ram_data_i : lines_i[hit_way_i];

    // stores answer with the merged word
    assign resp_word = sel_req.write ? merge_line_i[sel_woff * WORD_W +: WORD_W]
                                     : merge_word_i;

    assign lookup_index_o = sel_index;
    assign lookup_tag_o   = sel_tag;
    assign lru_way_o      = lru_q[sel_index];

    assign tag_wr_o    = (accept && hit_i && cpu_req_i.write) || refill_done;
    assign data_wr_o   = tag_wr_o;
    assign wr_way_o    = (state_q == S_REFILL) ? victim_q : hit_way_i;
    assign tag_entry_o = '{valid: 1'b1, dirty: sel_req.write, tag: sel_tag};
    assign line_o      = merge_line_i;

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= cpu_req_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= S_COMPARE;
            victim_q  <= '0;
            resp_q    <= '0;
            mem_req_q <= '0;
            for (int s = 0; s < SETS; s++) begin
                lru_q[s] <= '0;
            end
        end else begin
            resp_q.ready <= 1'b0;
            mem_req_q.rd <= 1'b0;  // one-cycle pulses
            mem_req_q.wb <= 1'b0;
            case (state_q)
                S_COMPARE: begin
                    if (accept && hit_i) begin
                        resp_q.ready     <= 1'b1;
                        resp_q.rdata     <= resp_word;
                        lru_q[sel_index] <= ~hit_way_i;
                    end else if (accept) begin
                        victim_q <= victim_way_i;
                        if (victim_dirty_i) begin
                            mem_req_q.wb      <= 1'b1;
                            mem_req_q.addr    <= {victim_tag_i, sel_index,
                                                  {INDEX_LSB{1'b0}}};
                            mem_req_q.wb_data <= lines_i[victim_way_i];
                            state_q           <= S_WRITE_BACK;
                        end else begin
                            mem_req_q.rd   <= 1'b1;
                            mem_req_q.addr <= line_addr;
                            state_q        <= S_REFILL;
                        end
                    end
                end
                S_WRITE_BACK: begin
                    if (ram_ready_i) begin
                        mem_req_q.rd   <= 1'b1;
                        mem_req_q.addr <= line_addr;
                        state_q        <= S_REFILL;
                    end
                end
                S_REFILL: begin
                    if (ram_ready_i) begin
                        resp_q.ready     <= 1'b1;
                        resp_q.rdata     <= resp_word;
                        lru_q[sel_index] <= ~victim_q;
                        state_q          <= S_COMPARE;
                    end
                end
                default: begin
                    state_q <= S_COMPARE;
                end
            endcase
        end
    end

    assign cpu_resp_o = resp_q;
    assign mem_req_o  = mem_req_q;

endmodule

// File: design/dcache_lookup.sv
/*
 * Tag lookup and victim choice
 * Compares the request tag against the valid ways of a set. The victim
 * is an invalid way if there is one, else a clean way, else the least
 * recently used way. Lower way numbers win ties.
 */
module dcache_lookup
    import dcache_pkg::*;
(
    input  tag_t       tag_i,
    input  tag_entry_t entries_i [WAYS],
    input  way_t       lru_way_i,
    output logic       hit_o,
    output way_t       hit_way_o,
    output way_t       victim_way_o,
    output logic       victim_dirty_o,
    output tag_t       victim_addr_tag_o
);

    logic inv_found;
    way_t inv_way;
    logic clean_found;
    way_t clean_way;
    way_t victim;

    always_comb begin
        hit_o       = 1'b0;
        hit_way_o   = '0;
        inv_found   = 1'b0;
        inv_way     = '0;
        clean_found = 1'b0;
        clean_way   = '0;
        // walk downwards so way 0 is taken last and wins
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (entries_i[w].valid && entries_i[w].tag == tag_i) begin
                hit_o     = 1'b1;
                hit_way_o = way_t'(w);
            end
            if (!entries_i[w].valid) begin
                inv_found = 1'b1;
                inv_way   = way_t'(w);
            end else if (!entries_i[w].dirty) begin
                clean_found = 1'b1;
                clean_way   = way_t'(w);
            end
        end
    end

    always_comb begin
        if (inv_found) begin
            victim = inv_way;
        end else if (clean_found) begin
            victim = clean_way;
        end else begin
            victim = lru_way_i;  // all ways dirty
        end
    end

    assign victim_way_o      = victim;
    assign victim_dirty_o    = entries_i[victim].valid & entries_i[victim].dirty;
    assign victim_addr_tag_o = entries_i[victim].tag;

endmodule

// File: design/dcache_pkg.sv
/*
 * Data cache package
 * Field widths of the address split, the line and word types, and the
 * request and response structs on the CPU and RAM sides.
 */
`include "dcache_settings.svh"

package dcache_pkg;

    localparam int ADDR_W     = `DC_ADDR_W;
    localparam int WORD_W     = `DC_WORD_W;
    localparam int LINE_BYTES = `DC_LINE_BYTES;
    localparam int LINE_W     = LINE_BYTES * 8;
    localparam int SETS       = `DC_SETS;
    localparam int WAYS       = `DC_WAYS;

    // | tag | index | word offset | byte offset |
    localparam int BOFF_W    = $clog2(WORD_W / 8);
    localparam int WOFF_W    = $clog2(LINE_BYTES / (WORD_W / 8));
    localparam int INDEX_W   = $clog2(SETS);
    localparam int TAG_W     = ADDR_W - INDEX_W - WOFF_W - BOFF_W;
    localparam int INDEX_LSB = BOFF_W + WOFF_W;
    localparam int TAG_LSB   = INDEX_LSB + INDEX_W;

    typedef logic [ADDR_W-1:0]       addr_t;
    typedef logic [WORD_W-1:0]       word_t;
    typedef logic [LINE_W-1:0]       line_t;
    typedef logic [TAG_W-1:0]        tag_t;
    typedef logic [INDEX_W-1:0]      index_t;
    typedef logic [WOFF_W-1:0]       woff_t;
    typedef logic [BOFF_W-1:0]       boff_t;
    typedef logic [$clog2(WAYS)-1:0] way_t;

    typedef enum logic [1:0] {
        WR_NONE = 2'd0,
        WR_BYTE = 2'd1,  // wdata[7:0]
        WR_HALF = 2'd2,  // wdata[15:0]
        WR_WORD = 2'd3
    } wr_width_e;

    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } tag_entry_t;

    typedef struct packed {
        logic      valid;
        logic      write;  // 1 for a store
        addr_t     addr;
        wr_width_e width;
        word_t     wdata;
    } cpu_req_t;

    typedef struct packed {
        logic  ready;
        word_t rdata;
    } cpu_resp_t;

    // rd and wb share the line-aligned addr
    typedef struct packed {
        logic  rd;
        logic  wb;
        addr_t addr;
        line_t wb_data;
    } mem_req_t;

endpackage

// File: design/dcache_settings.svh
/*
 * Data cache geometry
 * Two-way set associative, eight sets, 16-byte lines on a 32-bit
 * byte address.
 */
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// address and data bus widths
`define DC_ADDR_W     32
`define DC_WORD_W     32

// line size in bytes
`define DC_LINE_BYTES 16

`define DC_SETS       8
`define DC_WAYS       2

`endif

// File: design/dcache_store_merge.sv
/*
 * Store merge
 * Places the low byte, halfword or word of the store data into the
 * addressed lanes of a line, and selects the addressed word for loads.
 * Halfwords are aligned on bit 1 of the byte offset.
 */
module dcache_store_merge
    import dcache_pkg::*;
(
    input  line_t     line_i,
    input  woff_t     woff_i,
    input  boff_t     boff_i,
    input  wr_width_e width_i,
    input  word_t     wdata_i,
    output line_t     line_o,
    output word_t     word_o
);

    localparam int POS_W = $clog2(LINE_W);

    // bit position of the lowest lane touched
    logic [POS_W-1:0] byte_pos;
    logic [POS_W-1:0] half_pos;
    logic [POS_W-1:0] word_pos;

    always_comb begin
        byte_pos = {woff_i, boff_i, 3'b000};
        half_pos = {woff_i, boff_i[1], 4'b0000};  // low offset bit ignored
        word_pos = {woff_i, 5'b00000};
    end

    always_comb begin
        line_o = line_i;
        case (width_i)
            WR_BYTE: begin
                line_o[byte_pos +: 8] = wdata_i[7:0];
            end
            WR_HALF: begin
                line_o[half_pos +: 16] = wdata_i[15:0];
            end
            WR_WORD: begin
                line_o[word_pos +: WORD_W] = wdata_i;
            end
            default: begin
                // WR_NONE, line passes unchanged
            end
        endcase
    end

    assign word_o = line_i[word_pos +: WORD_W];

endmodule

// File: design/dcache_top.sv
/*
 * Data cache top level
 * Write-back, write-allocate, two ways by eight sets. Connects tag and
 * data storage, lookup, store merge and the miss controller.
 */
module dcache_top
    import dcache_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  cpu_req_t  cpu_req_i,
    output cpu_resp_t cpu_resp_o,
    output mem_req_t  mem_req_o,
    input  line_t     ram_data_i,
    input  logic      ram_ready_i
);

    tag_entry_t tags [WAYS];
    line_t      lines [WAYS];
    index_t     lookup_index;
    tag_t       lookup_tag;
    way_t       lru_way;
    logic       hit;
    way_t       hit_way;
    way_t       victim_way;
    logic       victim_dirty;
    tag_t       victim_tag;
    cpu_req_t   merge_req;
    line_t      merge_line_in;
    line_t      merge_line_out;
    word_t      merge_word;
    logic       tag_wr;
    logic       data_wr;
    way_t       wr_way;
    tag_entry_t tag_entry;
    line_t      wr_line;

    dcache_way_store #(.entry_t(tag_entry_t)) u_tag_store (
        .clk          (clk),
        .rst_n        (rst_n),
        .rd_index_i   (lookup_index),
        .rd_entries_o (tags),
        .wr_en_i      (tag_wr),
        .wr_index_i   (lookup_index),
        .wr_way_i     (wr_way),
        .wr_entry_i   (tag_entry)
    );

    dcache_way_store #(.entry_t(line_t)) u_data_store (
        .clk          (clk),
        .rst_n        (rst_n),
        .rd_index_i   (lookup_index),
        .rd_entries_o (lines),
        .wr_en_i      (data_wr),
        .wr_index_i   (lookup_index),
        .wr_way_i     (wr_way),
        .wr_entry_i   (wr_line)
    );

    dcache_lookup u_lookup (
        .tag_i             (lookup_tag),
        .entries_i         (tags),
        .lru_way_i         (lru_way),
        .hit_o             (hit),
        .hit_way_o         (hit_way),
        .victim_way_o      (victim_way),
        .victim_dirty_o    (victim_dirty),
        .victim_addr_tag_o (victim_tag)
    );

    dcache_store_merge u_merge (
        .line_i  (merge_line_in),
        .woff_i  (merge_req.addr[BOFF_W +: WOFF_W]),
        .boff_i  (merge_req.addr[0 +: BOFF_W]),
        .width_i (merge_req.width),
        .wdata_i (merge_req.wdata),
        .line_o  (merge_line_out),
        .word_o  (merge_word)
    );

    dcache_ctrl u_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .cpu_req_i      (cpu_req_i),
        .cpu_resp_o     (cpu_resp_o),
        .mem_req_o      (mem_req_o),
        .ram_data_i     (ram_data_i),
        .ram_ready_i    (ram_ready_i),
        .lookup_index_o (lookup_index),
        .lookup_tag_o   (lookup_tag),
        .lru_way_o      (lru_way),
        .hit_i          (hit),
        .hit_way_i      (hit_way),
        .victim_way_i   (victim_way),
        .victim_dirty_i (victim_dirty),
        .victim_tag_i   (victim_tag),
        .tags_i         (tags),
        .lines_i        (lines),
        .merge_req_o    (merge_req),
        .merge_line_o   (merge_line_in),
        .merge_line_i   (merge_line_out),
        .merge_word_i   (merge_word),
        .tag_wr_o       (tag_wr),
        .data_wr_o      (data_wr),
        .wr_way_o       (wr_way),
        .tag_entry_o    (tag_entry),
        .line_o         (wr_line)
    );

endmodule

// File: design/dcache_way_store.sv
/*
 * Way storage
 * One register per set and way. All ways of one set are read
 * combinationally, one way of one set is written per clock.
 */
module dcache_way_store
    import dcache_pkg::*;
#(
    parameter type entry_t = tag_entry_t
) (
    input  logic   clk,
    input  logic   rst_n,
    input  index_t rd_index_i,
    output entry_t rd_entries_o [WAYS],
    input  logic   wr_en_i,
    input  index_t wr_index_i,
    input  way_t   wr_way_i,
    input  entry_t wr_entry_i
);

    entry_t mem_q [SETS][WAYS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < SETS; s++) begin
                for (int w = 0; w < WAYS; w++) begin
                    mem_q[s][w] <= entry_t'('0);
                end
            end
        end else if (wr_en_i) begin
            mem_q[wr_index_i][wr_way_i] <= wr_entry_i;
        end
    end

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            rd_entries_o[w] = mem_q[rd_index_i][w];
        end
    end

endmodule

// File: run.sh
#!/usr/bin/env bash
# Builds the data cache testbench with Verilator and runs it.
# The exit status of the simulation is the result of the run.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f all.f --top-module dcache_tb -o dcache_sim

./obj_dir/dcache_sim

// File: verification/dcache_ram_model.sv
/*
 * RAM model for the data cache testbench
 * Line-wide reads and write-backs. Each request is answered with one
 * ready pulse after 1 to 6 cycles, drawn from an xorshift generator.
 * Raises overlap_o if a request arrives while another is outstanding.
 */
module dcache_ram_model
    import dcache_pkg::*;
(
    input  logic     clk,
    input  mem_req_t mem_req_i,
    output line_t    ram_data_o,
    output logic     ram_ready_o,
    output logic     overlap_o
);
    timeunit 1ns;
    timeprecision 100ps;

    line_t       mem [addr_t];  // lines written back so far
    mem_req_t    pend;
    logic        busy;
    int          wait_cnt;
    logic [31:0] rand_state;

    // initial content, a function of the whole word address
    function automatic word_t fill_word(input addr_t a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
    endfunction

    function automatic line_t read_line(input addr_t base);
        line_t l;
        if (mem.exists(base)) begin
            return mem[base];
        end
        for (int w = 0; w < LINE_BYTES / 4; w++) begin
            l[w*WORD_W +: WORD_W] = fill_word(base + addr_t'(4 * w));
        end
        return l;
    endfunction

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rand_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rand_state = x;
        return x;
    endfunction

    initial begin
        ram_data_o  = '0;
        ram_ready_o = 1'b0;
        overlap_o   = 1'b0;
        busy        = 1'b0;
        wait_cnt    = 0;
        rand_state  = 32'hc3bc;
        forever begin
            @(posedge clk);
            #1;
            ram_ready_o = 1'b0;  // single-cycle reply
            if (mem_req_i.rd || mem_req_i.wb) begin
                if (busy) begin
                    overlap_o = 1'b1;
                end
                busy     = 1'b1;
                pend     = mem_req_i;
                wait_cnt = 1 + int'(next_rand() % 32'd6);
                if (mem_req_i.wb) begin
                    mem[mem_req_i.addr] = mem_req_i.wb_data;
                end
            end else if (busy) begin
                wait_cnt--;
                if (wait_cnt == 0) begin
                    if (pend.rd) begin
                        ram_data_o = read_line(pend.addr);
                    end
                    ram_ready_o = 1'b1;
                    busy        = 1'b0;
                end
            end
        end
    end

endmodule

// File: verification/dcache_tb.sv
/*
 * Data cache testbench
 * Drives loads and stores of every width through hits, clean and dirty
 * misses and a random run, and checks each response against a golden
 * word memory.
 */
module dcache_tb
    import dcache_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int READY_TIMEOUT = 64;

    logic        clk;
    logic        rst_n;
    cpu_req_t    cpu_req;
    cpu_resp_t   cpu_resp;
    mem_req_t    mem_req;
    line_t       ram_data;
    logic        ram_ready;
    logic        ram_overlap;
    int          rd_count;
    int          wb_count;
    addr_t       last_rd_addr;
    int          ready_cycles;  // edges from drive to ready
    word_t       gold [addr_t];
    logic [31:0] rand_state;

    dcache_top u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .cpu_req_i   (cpu_req),
        .cpu_resp_o  (cpu_resp),
        .mem_req_o   (mem_req),
        .ram_data_i  (ram_data),
        .ram_ready_i (ram_ready)
    );

    dcache_ram_model u_ram (
        .clk         (clk),
        .mem_req_i   (mem_req),
        .ram_data_o  (ram_data),
        .ram_ready_o (ram_ready),
        .overlap_o   (ram_overlap)
    );

    always #5 clk = ~clk;

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            stop_run($sformatf("error %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            stop_run($sformatf("error %s: expected %b, actual %b", name, expected, actual));
        end
    endtask

    // same initial content as the RAM model
    function automatic word_t fill_word(input addr_t a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
    endfunction

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rand_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rand_state = x;
        return x;
    endfunction

    // golden memory; stores return the merged word, loads the stored word
    function automatic word_t ref_access(input addr_t addr, input logic write,
                                         input wr_width_e width, input word_t wdata);
        addr_t waddr;
        word_t cur;
        int    lo;
        int    n;
        waddr = {addr[31:2], 2'b00};
        cur   = gold.exists(waddr) ? gold[waddr] : fill_word(waddr);
        lo    = 0;
        n     = 0;
        if (write) begin
            case (width)
                WR_BYTE: begin
                    lo = int'(addr[1:0]);
                    n  = 1;
                end
                WR_HALF: begin
                    lo = addr[1] ? 2 : 0;
                    n  = 2;
                end
                WR_WORD: n = 4;
                default: n = 0;
            endcase
            for (int b = 0; b < 4; b++) begin
                if (b >= lo && b < lo + n) begin
                    cur[b*8 +: 8] = wdata[(b-lo)*8 +: 8];
                end
            end
            gold[waddr] = cur;
        end
        return cur;
    endfunction

    // one request, held until ready, then valid drops
    task automatic do_access(input string name, input addr_t addr, input logic write,
                             input wr_width_e width, input word_t wdata);
        word_t expected;
        cpu_req.valid = 1'b1;
        cpu_req.write = write;
        cpu_req.addr  = addr;
        cpu_req.width = width;
        cpu_req.wdata = wdata;
        ready_cycles  = 0;
        while (!cpu_resp.ready) begin
            @(posedge clk);
            #1;
            ready_cycles++;
            if (ready_cycles > READY_TIMEOUT) begin
                stop_run($sformatf("no ready within %0d cycles in %s", READY_TIMEOUT, name));
            end
        end
        expected = ref_access(addr, write, width, wdata);
        check_word(name, expected, cpu_resp.rdata);
        @(posedge clk);
        #1;
        cpu_req.valid = 1'b0;
    endtask

    // RAM request monitor
    always begin
        @(posedge clk);
        #1;
        if (mem_req.rd) begin
            rd_count++;
            last_rd_addr = mem_req.addr;
        end
        if (mem_req.wb) begin
            wb_count++;
        end
        if (ram_overlap) begin
            stop_run("RAM model got a request while another one was outstanding");
        end
    end

    initial begin
        int          rd_before;
        int          wb_before;
        logic [31:0] r;
        addr_t       addr;
        clk        = 1'b0;
        rst_n      = 1'b0;
        cpu_req    = '0;
        rd_count   = 0;
        wb_count   = 0;
        rand_state = 32'hc3bc;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_flag("reset ready", 1'b0, cpu_resp.ready);
        check_flag("reset rd", 1'b0, mem_req.rd);
        check_flag("reset wb", 1'b0, mem_req.wb);

        rd_before = rd_count;
        do_access("read miss", 32'h0000_0104, 1'b0, WR_WORD, '0);
        check_word("read miss rd pulses", 32'd1, word_t'(rd_count - rd_before));
        check_word("read miss rd address", 32'h0000_0100, last_rd_addr);

        rd_before = rd_count;
        do_access("read hit", 32'h0000_0108, 1'b0, WR_WORD, '0);
        check_word("read hit ready cycles", 32'd1, word_t'(ready_cycles));
        check_word("read hit rd pulses", 32'd0, word_t'(rd_count - rd_before));

        do_access("byte store hit", 32'h0000_0101, 1'b1, WR_BYTE, 32'h1234_56a5);
        do_access("byte store hit read", 32'h0000_0100, 1'b0, WR_NONE, '0);
        do_access("half store hit", 32'h0000_0106, 1'b1, WR_HALF, 32'hffff_beef);
        do_access("half store hit read", 32'h0000_0104, 1'b0, WR_NONE, '0);
        do_access("word store hit", 32'h0000_010c, 1'b1, WR_WORD, 32'hcafe_f00d);
        do_access("word store hit read", 32'h0000_010c, 1'b0, WR_NONE, '0);
        do_access("byte store miss", 32'h0000_0213, 1'b1, WR_BYTE, 32'h0000_003c);
        do_access("byte store miss read", 32'h0000_0210, 1'b0, WR_NONE, '0);
        do_access("half store miss", 32'h0000_0221, 1'b1, WR_HALF, 32'h0000_7e57);
        do_access("half store miss read", 32'h0000_0220, 1'b0, WR_NONE, '0);
        do_access("word store miss", 32'h0000_023a, 1'b1, WR_WORD, 32'h8badf00d);
        do_access("word store miss read", 32'h0000_0238, 1'b0, WR_NONE, '0);

        // set 5, clean lines only
        wb_before = wb_count;
        for (int i = 0; i < 4; i++) begin
            addr = 32'h0000_0050 + addr_t'(i % 3) * 32'h400;
            do_access($sformatf("set 5 read %0d", i), addr, 1'b0, WR_WORD, '0);
        end
        check_word("clean eviction write-backs", 32'd0, word_t'(wb_count - wb_before));

        // set 6, three dirty lines for two ways
        wb_before = wb_count;
        for (int i = 0; i < 3; i++) begin
            addr = 32'h0000_0064 + addr_t'(i) * 32'h400;
            do_access($sformatf("set 6 store %0d", i), addr, 1'b1, WR_WORD,
                      32'hd00d_0000 + word_t'(i));
        end
        for (int i = 0; i < 3; i++) begin
            addr = 32'h0000_0064 + addr_t'(i) * 32'h400;
            do_access($sformatf("set 6 read %0d", i), addr, 1'b0, WR_WORD, '0);
        end
        check_flag("dirty eviction write-back", 1'b1, wb_count > wb_before);

        for (int n = 0; n < 300; n++) begin
            r    = next_rand();
            addr = r & 32'h1000_01ff;
            r    = next_rand();
            do_access($sformatf("random access %0d", n), addr, r[2], wr_width_e'(r[1:0]),
                      next_rand());
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule
